//--- bench/bridge_tb.sv
// Testbench for the stream to UART bridge, run by run.sh under Verilator.
// Assumes the DUT idles from reset and that frames never overlap on txd_o.
// The UART decoder samples at mid-bit and needs CLOCKS_PER_BIT of at least 4.
`timescale 1ns/1ns
`default_nettype none

module bridge_tb;

	localparam int CLOCKS_PER_BIT = 8;
	localparam int BYTE_GAP       = 20;
	localparam int PACKET_GAP     = 60;
	localparam int FIFO_DEPTH     = 4;
	localparam int FRAME_W        = bt_pkg::FRAME_BYTES * bt_pkg::BYTE_W;

	logic                           clock = 1'b0;
	logic                           reset;
	logic                           wb_cyc;
	logic                           wb_stb;
	logic                           wb_we;
	logic [bt_pkg::STREAM_ID_W-1:0] wb_adr;
	logic [bt_pkg::SAMPLE_W-1:0]    wb_dat;
	logic                           wb_ack;
	logic                           send_enable;
	logic                           txd_o;

	logic [FRAME_W-1:0] exp_q [$];
	logic [FRAME_W-1:0] rx_q [$];
	logic [FRAME_W-1:0] rx_shift;
	int                 rx_count = 0;
	logic [31:0]        rng = 32'h192f;
	string              cur_test = "reset state";
	int                 errors = 0;
	int                 checks = 0;
	int                 tests = 0;
	int                 test_start_errors = 0;

	stream_uart_bridge #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT), .BYTE_GAP(BYTE_GAP),
		.PACKET_GAP(PACKET_GAP), .FIFO_DEPTH(FIFO_DEPTH)
	) DUT (
		.clock(clock), .reset(reset),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat), .wb_ack_o(wb_ack),
		.send_enable_i(send_enable), .txd_o(txd_o)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Id byte, payload MSB first, id byte again
	function automatic logic [FRAME_W-1:0] expected_frame(
		input logic [bt_pkg::STREAM_ID_W-1:0] id, input logic [bt_pkg::SAMPLE_W-1:0] sample);
		logic [bt_pkg::BYTE_W-1:0] id_byte;
		id_byte = bt_pkg::BYTE_W'(id);
		return {id_byte, sample, id_byte};
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual)
		begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic next_drive_slot();
		@(posedge clock);
		#5;
	endtask

	task automatic start_cycle(input logic [bt_pkg::STREAM_ID_W-1:0] id,
		input logic [bt_pkg::SAMPLE_W-1:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = id;
		wb_dat = data;
	endtask

	// Ack is sampled mid-cycle and the write lands on the following edge
	task automatic wait_ack(input int limit, output bit acked);
		int n;
		n = 0;
		acked = 1'b0;
		while (!acked && n < limit)
		begin
			@(negedge clock);
			if (wb_ack)
				acked = 1'b1;
			n++;
		end
	endtask

	task automatic release_bus();
		@(posedge clock);
		#5;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// Call at a drive slot; returns at the next one
	task automatic write_sample(input logic [bt_pkg::STREAM_ID_W-1:0] id,
		output logic [bt_pkg::SAMPLE_W-1:0] data);
		bit acked;
		rng = xorshift(rng);
		data = rng;
		start_cycle(id, data);
		wait_ack(20, acked);
		if (!acked)
		begin
			$display("Write to stream %0d in %s was never acknowledged", id, cur_test);
			errors++;
		end
		release_bus();
	endtask

	task automatic wait_frames();
		int n;
		int limit;
		n = 0;
		limit = 1000 * exp_q.size() + 100;
		while (exp_q.size() != 0 && n < limit)
		begin
			@(negedge clock);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			$display("Timeout in %s: %0d frames never arrived", cur_test, exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	// Covers the stop bit tail and the packet gap so the sequencer is back in IDLE
	task automatic settle_idle();
		repeat (PACKET_GAP + 3 * CLOCKS_PER_BIT) @(negedge clock);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_start_errors = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("%-20s %s", cur_test, (errors == test_start_errors) ? "ok" : "failed");
	endtask

	// UART line decoder that gathers bytes into frames
	always
	begin : uart_decoder
		logic [bt_pkg::BYTE_W-1:0] rx_byte;
		@(negedge clock);
		if (!reset && txd_o == 1'b0)
		begin
			repeat (CLOCKS_PER_BIT / 2 - 1) @(negedge clock);
			for (int i = 0; i < bt_pkg::BYTE_W; i++)
			begin
				repeat (CLOCKS_PER_BIT) @(negedge clock);
				rx_byte[i] = txd_o;
			end
			repeat (CLOCKS_PER_BIT) @(negedge clock);
			if (txd_o !== 1'b1)
			begin
				$display("Framing error in %s: stop bit on txd_o was low", cur_test);
				errors++;
			end
			rx_shift = {rx_shift[FRAME_W-bt_pkg::BYTE_W-1:0], rx_byte};
			rx_count++;
			if (rx_count == bt_pkg::FRAME_BYTES)
			begin
				rx_q.push_back(rx_shift);
				rx_count = 0;
			end
		end
	end

	// Received frames against the expected queue
	always @(posedge clock)
	begin
		while (rx_q.size() != 0)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Unexpected frame %h on txd_o in %s", rx_q[0], cur_test);
				errors++;
				void'(rx_q.pop_front());
			end
			else
				check_value(cur_test, 64'(exp_q.pop_front()), 64'(rx_q.pop_front()));
		end
	end

	initial
	begin
		logic [bt_pkg::SAMPLE_W-1:0] d [4];
		bit acked;
		int lows;

		// A write request held through reset must not be acked
		reset = 1'b1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = '0;
		wb_dat = '0;
		send_enable = 1'b0;

		begin_test("reset state");
		repeat (5) @(negedge clock);
		check_value("txd_o in reset", 64'(1), 64'(txd_o));
		check_value("wb_ack_o in reset", 64'(0), 64'(wb_ack));
		repeat (5) @(posedge clock);
		#5;
		reset = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		repeat (3) @(negedge clock);
		check_value("txd_o after reset", 64'(1), 64'(txd_o));
		check_value("wb_ack_o after reset", 64'(0), 64'(wb_ack));
		end_test();

		begin_test("single frame");
		next_drive_slot();
		send_enable = 1'b1;
		write_sample(2'd2, d[0]);
		exp_q.push_back(expected_frame(2'd2, d[0]));
		wait_frames();
		settle_idle();
		end_test();

		begin_test("stream order");
		next_drive_slot();
		for (int i = 0; i < 3; i++)
		begin
			write_sample(2'd1, d[i]);
			exp_q.push_back(expected_frame(2'd1, d[i]));
		end
		wait_frames();
		settle_idle();
		end_test();

		begin_test("round robin");
		next_drive_slot();
		write_sample(2'd1, d[0]);
		write_sample(2'd0, d[1]);
		write_sample(2'd2, d[2]);
		write_sample(2'd1, d[3]);
		exp_q.push_back(expected_frame(2'd1, d[0]));
		exp_q.push_back(expected_frame(2'd2, d[2]));
		exp_q.push_back(expected_frame(2'd0, d[1]));
		exp_q.push_back(expected_frame(2'd1, d[3]));
		wait_frames();
		settle_idle();
		end_test();

		begin_test("back pressure");
		next_drive_slot();
		send_enable = 1'b0;
		for (int i = 0; i < FIFO_DEPTH; i++)
		begin
			write_sample(2'd3, d[0]);
			exp_q.push_back(expected_frame(2'd3, d[0]));
		end
		rng = xorshift(rng);
		exp_q.push_back(expected_frame(2'd3, rng));
		start_cycle(2'd3, rng);
		wait_ack(50, acked);
		check_value("no ack while FIFO full", 64'(0), 64'(acked));
		next_drive_slot();
		send_enable = 1'b1;
		wait_ack(2000, acked);
		if (!acked)
		begin
			$display("Write to full stream 3 was never acknowledged after a pop");
			errors++;
		end
		release_bus();
		wait_frames();
		settle_idle();
		end_test();

		begin_test("send enable gating");
		next_drive_slot();
		send_enable = 1'b0;
		write_sample(2'd0, d[0]);
		exp_q.push_back(expected_frame(2'd0, d[0]));
		lows = 0;
		repeat (2000)
		begin
			@(negedge clock);
			if (txd_o !== 1'b1)
				lows++;
		end
		check_value("txd_o low cycles while disabled", 64'(0), 64'(lows));
		next_drive_slot();
		send_enable = 1'b1;
		wait_frames();
		settle_idle();
		end_test();

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
logic/bt_pkg.sv
logic/stream_read_if.sv
logic/sample_fifo_bank.sv
logic/stream_arbiter.sv
logic/packet_sequencer.sv
logic/uart_transmitter.sv
logic/stream_uart_bridge.sv
bench/bridge_tb.sv

//--- logic/bt_pkg.sv
// Shared widths, frame layout and enums for the sensor stream to UART bridge.
// STREAM_COUNT must equal 2**STREAM_ID_W so that stream indices wrap cleanly.
// A frame is the id byte, the payload MSB first, then the id byte again.
`default_nettype none

package bt_pkg;

	localparam int STREAM_COUNT  = 4;
	localparam int STREAM_ID_W   = 2;
	localparam int PAYLOAD_BYTES = 4;
	localparam int BYTE_W        = 8;
	localparam int SAMPLE_W      = PAYLOAD_BYTES * BYTE_W;

	// Payload plus an id byte at each end
	localparam int FRAME_BYTES = PAYLOAD_BYTES + 2;

	typedef logic [2:0] byte_index_t;

	typedef enum logic [2:0] {
		IDLE,
		POP,
		LOAD,
		SEND_BYTE,
		BYTE_GAP,
		PACKET_GAP
	} seq_state_t;

	// Which field feeds the current UART byte
	typedef enum logic {
		OP_ID,
		OP_PAYLOAD
	} frame_op_t;

	typedef struct packed {
		logic [STREAM_ID_W-1:0] id;
		logic [SAMPLE_W-1:0]    payload;
	} packet_t;

endpackage

`default_nettype wire

//--- logic/packet_sequencer.sv
// Pops one granted sample, frames it and hands the bytes to the UART one by one.
// BYTE_GAP and PACKET_GAP must both be at least 1.
// send_enable_i is only looked at in IDLE, so a begun packet always completes.
`timescale 1ns/1ns
`default_nettype none

module packet_sequencer #(
	parameter int BYTE_GAP   = 20,
	parameter int PACKET_GAP = 60
) (
	input  wire                        clock,
	input  wire                        reset,
	input  wire                        send_enable_i,
	stream_read_if.sequencer           rd,
	output logic                       tx_start,
	output logic [bt_pkg::BYTE_W-1:0]  tx_data,
	input  wire                        tx_busy
);

	localparam int GAP_MAX = (BYTE_GAP > PACKET_GAP) ? BYTE_GAP : PACKET_GAP;
	localparam int GAP_W = $clog2(GAP_MAX + 1);

	bt_pkg::seq_state_t  state_q;
	bt_pkg::packet_t     frame_q;
	bt_pkg::byte_index_t byte_idx;
	bt_pkg::frame_op_t   op;
	logic [GAP_W-1:0]    gap_cnt;
	logic                tx_start_q;

	assign rd.pop = (state_q == bt_pkg::POP);
	assign tx_start = tx_start_q;

	// Id at both ends of the frame, payload in between
	assign op = (byte_idx == '0 || byte_idx == bt_pkg::byte_index_t'(bt_pkg::FRAME_BYTES - 1))
		? bt_pkg::OP_ID : bt_pkg::OP_PAYLOAD;

	always_comb
	begin
		if (op == bt_pkg::OP_ID)
			tx_data = bt_pkg::BYTE_W'(frame_q.id);
		else
			tx_data = frame_q.payload[(bt_pkg::PAYLOAD_BYTES - int'(byte_idx)) * bt_pkg::BYTE_W
				+: bt_pkg::BYTE_W];
	end

	// Sample and id are captured on the pop edge, before the head moves
	always_ff @(posedge clock)
	begin
		if (state_q == bt_pkg::POP)
			frame_q <= {rd.grant_id, rd.head[rd.grant_id]};
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state_q <= bt_pkg::IDLE;
			byte_idx <= '0;
			gap_cnt <= '0;
			tx_start_q <= 1'b0;
		end
		else
		begin
			tx_start_q <= 1'b0;
			case (state_q)
				bt_pkg::IDLE:
				begin
					if (send_enable_i && rd.grant_valid)
						state_q <= bt_pkg::POP;
				end
				bt_pkg::POP:
				begin
					state_q <= bt_pkg::LOAD;
				end
				bt_pkg::LOAD:
				begin
					byte_idx <= '0;
					tx_start_q <= 1'b1;
					state_q <= bt_pkg::SEND_BYTE;
				end
				bt_pkg::SEND_BYTE:
				begin
					// Busy only rises the cycle after the start pulse
					if (!tx_start_q && !tx_busy)
					begin
						gap_cnt <= '0;
						if (byte_idx == bt_pkg::byte_index_t'(bt_pkg::FRAME_BYTES - 1))
							state_q <= bt_pkg::PACKET_GAP;
						else
							state_q <= bt_pkg::BYTE_GAP;
					end
				end
				bt_pkg::BYTE_GAP:
				begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_cnt == GAP_W'(BYTE_GAP - 1))
					begin
						byte_idx <= byte_idx + 1'b1;
						tx_start_q <= 1'b1;
						state_q <= bt_pkg::SEND_BYTE;
					end
				end
				bt_pkg::PACKET_GAP:
				begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_cnt == GAP_W'(PACKET_GAP - 1))
						state_q <= bt_pkg::IDLE;
				end
				default:
				begin
					state_q <= bt_pkg::IDLE;
				end
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset) tx_start |-> !tx_busy);

endmodule

`default_nettype wire

//--- logic/sample_fifo_bank.sv
// One circular sample FIFO per stream behind a write-only Wishbone classic slave.
// FIFO_DEPTH must be a power of two, at least 2.
// Ack is withheld while the addressed FIFO is full; reads are acked with no effect.
// The sample is stored on the edge that ends the ack cycle.
`timescale 1ns/1ns
`default_nettype none

module sample_fifo_bank #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire                              clock,
	input  wire                              reset,
	input  wire                              wb_cyc_i,
	input  wire                              wb_stb_i,
	input  wire                              wb_we_i,
	input  wire [bt_pkg::STREAM_ID_W-1:0]    wb_adr_i,
	input  wire [bt_pkg::SAMPLE_W-1:0]       wb_dat_i,
	output logic                             wb_ack_o,
	stream_read_if.fifo                      rd
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [bt_pkg::SAMPLE_W-1:0] mem [bt_pkg::STREAM_COUNT][FIFO_DEPTH];
	logic [PTR_W-1:0]            wr_ptr [bt_pkg::STREAM_COUNT];
	logic [PTR_W-1:0]            rd_ptr [bt_pkg::STREAM_COUNT];
	logic [PTR_W:0]              count [bt_pkg::STREAM_COUNT];
	logic [bt_pkg::STREAM_COUNT-1:0] full;
	logic                        ack_q;
	logic                        push;

	assign push = ack_q && wb_we_i;
	assign wb_ack_o = ack_q;

	always_comb
	begin
		for (int i = 0; i < bt_pkg::STREAM_COUNT; i++)
		begin
			full[i] = (count[i] == (PTR_W + 1)'(FIFO_DEPTH));
			rd.not_empty[i] = (count[i] != '0);
			rd.head[i] = mem[i][rd_ptr[i]];
		end
	end

	// Single-cycle ack, one cycle after a valid cycle to a FIFO with room
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			ack_q <= 1'b0;
		else
			ack_q <= wb_cyc_i && wb_stb_i && !ack_q && (!wb_we_i || !full[wb_adr_i]);
	end

	always_ff @(posedge clock)
	begin
		if (push)
			mem[wb_adr_i][wr_ptr[wb_adr_i]] <= wb_dat_i;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < bt_pkg::STREAM_COUNT; i++)
			begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				count[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < bt_pkg::STREAM_COUNT; i++)
			begin
				if (push && wb_adr_i == bt_pkg::STREAM_ID_W'(i))
					wr_ptr[i] <= wr_ptr[i] + 1'b1;
				if (rd.pop && rd.grant_id == bt_pkg::STREAM_ID_W'(i))
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				// Simultaneous push and pop leave the count alone
				if ((push && wb_adr_i == bt_pkg::STREAM_ID_W'(i))
						&& !(rd.pop && rd.grant_id == bt_pkg::STREAM_ID_W'(i)))
					count[i] <= count[i] + 1'b1;
				else if (!(push && wb_adr_i == bt_pkg::STREAM_ID_W'(i))
						&& (rd.pop && rd.grant_id == bt_pkg::STREAM_ID_W'(i)))
					count[i] <= count[i] - 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset) push |-> !full[wb_adr_i]);
	assert property (@(posedge clock) disable iff (reset) rd.pop |-> rd.not_empty[rd.grant_id]);

endmodule

`default_nettype wire

//--- logic/stream_arbiter.sv
// Round-robin choice of the next non-empty stream.
// Grant is combinational; the last-served pointer moves only on pop.
// After reset stream 0 has first claim.
`timescale 1ns/1ns
`default_nettype none

module stream_arbiter (
	input  wire            clock,
	input  wire            reset,
	stream_read_if.arbiter rd
);

	logic [bt_pkg::STREAM_ID_W-1:0] last_q;
	logic [bt_pkg::STREAM_ID_W-1:0] grant_id;
	logic                           grant_valid;

	// Walk backwards so the stream nearest after last_q is the one kept
	always_comb
	begin
		logic [bt_pkg::STREAM_ID_W-1:0] cand;
		grant_valid = 1'b0;
		grant_id = last_q;
		for (int k = bt_pkg::STREAM_COUNT; k >= 1; k--)
		begin
			cand = last_q + bt_pkg::STREAM_ID_W'(k);
			if (rd.not_empty[cand])
			begin
				grant_valid = 1'b1;
				grant_id = cand;
			end
		end
	end

	assign rd.grant_valid = grant_valid;
	assign rd.grant_id = grant_id;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			last_q <= bt_pkg::STREAM_ID_W'(bt_pkg::STREAM_COUNT - 1);
		else if (rd.pop)
			last_q <= grant_id;
	end

	assert property (@(posedge clock) disable iff (reset)
		(grant_valid == (rd.not_empty != '0)) && (grant_valid -> rd.not_empty[grant_id]));

endmodule

`default_nettype wire

//--- logic/stream_read_if.sv
// Read path from the FIFO bank through the arbiter to the sequencer.
// pop is a single-cycle pulse and removes the head of stream grant_id.
`timescale 1ns/1ns
`default_nettype none

interface stream_read_if;

	logic [bt_pkg::STREAM_COUNT-1:0] not_empty;
	logic [bt_pkg::SAMPLE_W-1:0]     head [bt_pkg::STREAM_COUNT];
	logic                            grant_valid;
	logic [bt_pkg::STREAM_ID_W-1:0]  grant_id;
	logic                            pop;

	modport fifo (output not_empty, output head, input grant_id, input pop);

	modport arbiter (input not_empty, output grant_valid, output grant_id, input pop);

	modport sequencer (input grant_valid, input grant_id, input head, output pop);

endinterface

`default_nettype wire

//--- logic/stream_uart_bridge.sv
// Sensor sample streams in over Wishbone, framed packets out on a UART line.
// All timing comes from the parameters below; FIFO_DEPTH must be a power of two.
// wb_adr_i selects the stream, wb_dat_i carries one whole sample.
`timescale 1ns/1ns
`default_nettype none

module stream_uart_bridge #(
	parameter int CLOCKS_PER_BIT = 8,
	parameter int BYTE_GAP       = 20,
	parameter int PACKET_GAP     = 60,
	parameter int FIFO_DEPTH     = 4
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            wb_cyc_i,
	input  wire                            wb_stb_i,
	input  wire                            wb_we_i,
	input  wire [bt_pkg::STREAM_ID_W-1:0]  wb_adr_i,
	input  wire [bt_pkg::SAMPLE_W-1:0]     wb_dat_i,
	output logic                           wb_ack_o,
	input  wire                            send_enable_i,
	output logic                           txd_o
);

	logic                      tx_start;
	logic [bt_pkg::BYTE_W-1:0] tx_data;
	logic                      tx_busy;

	stream_read_if rd_if ();

	sample_fifo_bank #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo_bank (
		.clock(clock), .reset(reset),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_ack_o(wb_ack_o),
		.rd(rd_if.fifo)
	);

	stream_arbiter u_arbiter (.clock(clock), .reset(reset), .rd(rd_if.arbiter));

	packet_sequencer #(.BYTE_GAP(BYTE_GAP), .PACKET_GAP(PACKET_GAP)) u_sequencer (
		.clock(clock), .reset(reset), .send_enable_i(send_enable_i),
		.rd(rd_if.sequencer),
		.tx_start(tx_start), .tx_data(tx_data), .tx_busy(tx_busy)
	);

	uart_transmitter #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) u_uart_tx (
		.clock(clock), .reset(reset),
		.tx_start(tx_start), .tx_data(tx_data),
		.tx_busy(tx_busy), .txd_o(txd_o)
	);

endmodule

`default_nettype wire

//--- logic/uart_transmitter.sv
// 8N1 transmitter, LSB first, line idles high.
// tx_start is taken only while tx_busy is low.
// Busy falls 10*CLOCKS_PER_BIT+1 cycles after the start pulse.
`timescale 1ns/1ns
`default_nettype none

module uart_transmitter #(
	parameter int CLOCKS_PER_BIT = 8
) (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       tx_start,
	input  wire [bt_pkg::BYTE_W-1:0]  tx_data,
	output logic                      tx_busy,
	output logic                      txd_o
);

	localparam int CNT_W = (CLOCKS_PER_BIT > 1) ? $clog2(CLOCKS_PER_BIT) : 1;

	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_cnt;
	logic [9:0]       shift_q;

	// Line follows the low end of the shift register
	assign txd_o = shift_q[0];

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			shift_q <= '1;
		end
		else if (!tx_busy)
		begin
			if (tx_start)
			begin
				tx_busy <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
				// Stop bit, data, start bit
				shift_q <= {1'b1, tx_data, 1'b0};
			end
		end
		else if (clk_cnt == CNT_W'(CLOCKS_PER_BIT - 1))
		begin
			clk_cnt <= '0;
			shift_q <= {1'b1, shift_q[9:1]};
			if (bit_cnt == 4'd9)
				tx_busy <= 1'b0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end
		else
		begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator and runs it.
# Exit status is zero only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module bridge_tb \
	--Mdir obj_dir -o bridge_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/bridge_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
